/* Bender.yml */
package:
  name: conv_input_pipe

export_include_dirs:
  - logic

sources:
  - logic/conv_in_pkg.sv
  - logic/weight_seq_fsm.sv
  - logic/kernel_col_counter.sv
  - logic/weight_rotator.sv
  - logic/pixel_pipe.sv
  - logic/conv_input_pipe.sv
  - target: test
    files:
      - dv/conv_input_pipe_asserts.sv
      - dv/conv_input_pipe_tb.sv

/* dv/conv_input_pipe_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_input_pipe_asserts (
  input wire                          aclk,
  input wire                          rst_n,
  input wire                          m_valid,
  input wire                          m_ready,
  input wire                          m_last,
  input wire conv_in_pkg::conv_user_t m_user
);

  int fail_count = 0;

  // An offered beat stays up until it is taken.
  hold_valid: assert property (@(posedge aclk) disable iff (!rst_n)
    m_valid && !m_ready |=> m_valid)
  else begin
    $error("m_valid dropped while m_ready was low");
    fail_count++;
  end

  last_in_beat: assert property (@(posedge aclk) disable iff (!rst_n)
    m_last |-> m_valid)
  else begin
    $error("m_last high without m_valid");
    fail_count++;
  end

  tag_in_beat: assert property (@(posedge aclk) disable iff (!rst_n)
    (m_user.tag.is_w_first || m_user.tag.is_cin_last || m_user.tag.is_col_valid) |-> m_valid)
  else begin
    $error("w_tag flag high without m_valid");
    fail_count++;
  end

endmodule

`default_nettype wire

/* dv/conv_input_pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_input_pipe_tb;

  localparam int TIMEOUT_CYCLES = 2000;
  localparam conv_in_pkg::pix_mode_t MODE_NOT_MAX = '{1'b1, 1'b0, 1'b0};
  localparam conv_in_pkg::pix_mode_t MODE_MAX     = '{1'b0, 1'b1, 1'b0};
  localparam conv_in_pkg::pix_mode_t MODE_LRELU   = '{1'b0, 1'b0, 1'b1};

  typedef struct packed {
    logic                   last;
    conv_in_pkg::pix_data_t data;
  } pix_in_t;

  typedef struct packed {
    logic               last;
    conv_in_pkg::wcol_t data;
  } w_in_t;

  typedef struct packed {
    conv_in_pkg::pix_mode_t mode;
    conv_in_pkg::pix_data_t data;
  } pix_exp_t;

  typedef struct packed {
    logic                last;
    conv_in_pkg::w_tag_t tag;
    conv_in_pkg::wcol_t  data;
  } w_exp_t;

  typedef struct packed {
    logic                    last;
    conv_in_pkg::conv_user_t user;
    conv_in_pkg::pix_data_t  pix;
    conv_in_pkg::wcol_t      w;
  } out_beat_t;

  logic                    aclk;
  logic                    rst_n;
  logic                    s_pixels_valid;
  logic                    s_pixels_ready;
  logic                    s_pixels_last;
  conv_in_pkg::pix_data_t  s_pixels_data;
  logic                    s_weights_valid;
  logic                    s_weights_ready;
  logic                    s_weights_last;
  conv_in_pkg::wcol_t      s_weights_data;
  logic                    m_ready;
  logic                    m_valid;
  logic                    m_last;
  conv_in_pkg::conv_user_t m_user;
  conv_in_pkg::pix_data_t  m_pixels_data;
  conv_in_pkg::wcol_t      m_weights_data;

  pix_in_t   pix_in[$];
  w_in_t     w_in[$];
  pix_exp_t  exp_pix[$];
  w_exp_t    exp_w[$];
  out_beat_t exp_q[$];

  integer seed   = 43;
  int     errors = 0;
  int     checks = 0;
  int     tests  = 0;
  int     cycles = 0;

  conv_input_pipe dut_i (.*);

  bind conv_input_pipe conv_input_pipe_asserts asserts_i (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_last  (m_last),
    .m_user  (m_user)
  );

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ************************************************************
  // Stimulus and reference model
  // ************************************************************

  task automatic add_pixel_packet(input conv_in_pkg::pix_mode_t mode, input int beats);
    pix_in_t  b;
    pix_exp_t e;
    b.data = conv_in_pkg::pix_data_t'($random(seed));
    b.data[0][$bits(conv_in_pkg::pix_mode_t)-1:0] = mode;   // Header beat.
    b.last = 1'b0;
    pix_in.push_back(b);
    for (int i = 0; i < beats; i++) begin
      b.data = conv_in_pkg::pix_data_t'($random(seed));
      b.last = (i == beats - 1);
      pix_in.push_back(b);
      e.mode = mode;
      e.data = b.data;
      exp_pix.push_back(e);
    end
  endtask

  task automatic add_weight_set(input int kw, input int reps);
    w_in_t               b;
    w_exp_t              e;
    conv_in_pkg::w_cfg_t cfg;
    conv_in_pkg::wcol_t  cols[$];
    cfg.kw   = conv_in_pkg::kw_t'(kw);
    cfg.reps = conv_in_pkg::rep_t'(reps);
    b.data = '0;
    b.data[0][$bits(conv_in_pkg::w_cfg_t)-1:0] = cfg;
    b.last = 1'b0;
    w_in.push_back(b);
    for (int k = 0; k < kw; k++) begin
      b.data = conv_in_pkg::wcol_t'($random(seed));
      b.last = (k == kw - 1);
      w_in.push_back(b);
      cols.push_back(b.data);
    end
    // Column k of round r.
    for (int r = 0; r < reps; r++) begin
      for (int k = 0; k < kw; k++) begin
        e.data             = cols[k];
        e.tag.kw2          = conv_in_pkg::kw_t'(kw / 2);
        e.tag.is_w_first   = (k == 0);
        e.tag.is_cin_last  = (r == reps - 1);
        e.tag.is_col_valid = 1'b1;
        e.last             = (k == kw - 1) && (r == reps - 1);
        exp_w.push_back(e);
      end
    end
  endtask

  task automatic drive_pixels(input int gap);
    pix_in_t b;
    while (pix_in.size() > 0) begin
      b = pix_in.pop_front();
      while (({$random(seed)} % 100) < gap) begin
        s_pixels_valid <= 1'b0;
        @(posedge aclk);
      end
      s_pixels_valid <= 1'b1;
      s_pixels_last  <= b.last;
      s_pixels_data  <= b.data;
      do @(negedge aclk); while (!s_pixels_ready);
      @(posedge aclk);
    end
    s_pixels_valid <= 1'b0;
  endtask

  task automatic drive_weights(input int gap);
    w_in_t b;
    while (w_in.size() > 0) begin
      b = w_in.pop_front();
      while (({$random(seed)} % 100) < gap) begin
        s_weights_valid <= 1'b0;
        @(posedge aclk);
      end
      s_weights_valid <= 1'b1;
      s_weights_last  <= b.last;
      s_weights_data  <= b.data;
      do @(negedge aclk); while (!s_weights_ready);
      @(posedge aclk);
    end
    s_weights_valid <= 1'b0;
  endtask

  // ************************************************************
  // Checks
  // ************************************************************

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %0d ns: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic collect_outputs(input int n, input int stall, input bit hold_check);
    out_beat_t got;
    out_beat_t exp;
    int        count;
    count = 0;
    while (count < n) begin
      @(posedge aclk);
      m_ready <= (({$random(seed)} % 100) >= stall);
      @(negedge aclk);
      if (hold_check && count > 0) begin
        check_bit("s_weights_ready during replay", s_weights_ready, 1'b0);
      end
      if (m_valid && m_ready) begin
        got.last = m_last;
        got.user = m_user;
        got.pix  = m_pixels_data;
        got.w    = m_weights_data;
        exp      = exp_q.pop_front();
        checks++;
        assert (got == exp) else begin
          $display("[ERROR] %0d ns: beat %0d is %h, expected %h", $time, count, got, exp);
          errors++;
        end
        count++;
      end
    end
    @(posedge aclk);   // Last beat leaves here.
    m_ready <= 1'b0;
  endtask

  task automatic run_traffic(input int gap, input int stall, input bit hold_check);
    pix_exp_t  pe;
    w_exp_t    we;
    out_beat_t b;
    // The join pairs the two streams beat by beat.
    while (exp_pix.size() > 0 && exp_w.size() > 0) begin
      pe          = exp_pix.pop_front();
      we          = exp_w.pop_front();
      b.last      = we.last;
      b.user.mode = pe.mode;
      b.user.tag  = we.tag;
      b.pix       = pe.data;
      b.w         = we.data;
      exp_q.push_back(b);
    end
    @(posedge aclk);
    fork
      drive_pixels(gap);
      drive_weights(gap);
      collect_outputs(exp_q.size(), stall, hold_check);
    join
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    $display("Test %-16s %s (%0d errors)", name,
             (errors == errors_before) ? "ok" : "failed", errors - errors_before);
  endtask

  // ************************************************************
  // Tests
  // ************************************************************

  task automatic test_reset_state();
    int errors_before;
    errors_before = errors;
    @(negedge aclk);
    check_bit("m_valid", m_valid, 1'b0);
    check_bit("s_pixels_ready", s_pixels_ready, 1'b1);
    check_bit("s_weights_ready", s_weights_ready, 1'b1);
    report_test("reset", errors_before);
  endtask

  task automatic test_replay(input string name, input int gap, input int stall);
    int errors_before;
    errors_before = errors;
    add_weight_set(3, 4);
    add_pixel_packet(MODE_NOT_MAX, 12);
    run_traffic(gap, stall, 1'b1);
    @(negedge aclk);
    check_bit("s_weights_ready after the last beat", s_weights_ready, 1'b1);
    check_bit("m_valid after the last beat", m_valid, 1'b0);
    report_test(name, errors_before);
  endtask

  task automatic test_single_round();
    int errors_before;
    errors_before = errors;
    add_weight_set(3, 1);
    add_pixel_packet(MODE_NOT_MAX, 3);
    run_traffic(0, 0, 1'b0);
    report_test("single_round", errors_before);
  endtask

  task automatic test_pixel_modes();
    int errors_before;
    errors_before = errors;
    add_weight_set(3, 4);
    add_pixel_packet(MODE_MAX, 5);
    add_pixel_packet(MODE_LRELU, 7);
    run_traffic(0, 0, 1'b0);
    report_test("pixel_modes", errors_before);
  endtask

  task automatic test_back_to_back();
    int errors_before;
    errors_before = errors;
    add_weight_set(1, 2);
    add_weight_set(3, 2);
    add_pixel_packet(MODE_MAX, 4);
    add_pixel_packet(MODE_LRELU, 4);
    run_traffic(10, 20, 1'b0);
    report_test("back_to_back", errors_before);
  endtask

  initial begin
    rst_n           = 1'b0;
    s_pixels_valid  = 1'b0;
    s_pixels_last   = 1'b0;
    s_pixels_data   = '0;
    s_weights_valid = 1'b0;
    s_weights_last  = 1'b0;
    s_weights_data  = '0;
    m_ready         = 1'b0;
    repeat (4) @(posedge aclk);
    rst_n <= 1'b1;
    test_reset_state();
    test_single_round();
    test_replay("four_rounds", 0, 0);
    test_pixel_modes();
    test_replay("random_stalls", 30, 40);
    test_back_to_back();
    errors += dut_i.asserts_i.fail_count;
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/conv_in_pkg.sv
logic/weight_seq_fsm.sv
logic/kernel_col_counter.sv
logic/weight_rotator.sv
logic/pixel_pipe.sv
logic/conv_input_pipe.sv
dv/conv_input_pipe_asserts.sv
dv/conv_input_pipe_tb.sv

/* logic/conv_in_cfg.svh */
`ifndef CONV_IN_CFG_SVH
`define CONV_IN_CFG_SVH

// ************************************************************
// Array size
// ************************************************************

`define CONV_ROWS        4   // Pixel words per beat.
`define CONV_COLS        4   // Weight words per column.
`define CONV_WORD_WIDTH  8

// ************************************************************
// Kernel limits
// ************************************************************

// Must stay odd.
`define CONV_KW_MAX      3
`define CONV_REPS_MAX    8   // Input-channel passes per weight set.

`endif

/* logic/conv_in_pkg.sv */
`default_nettype none
`include "conv_in_cfg.svh"

package conv_in_pkg;

  // Data words.
  typedef logic [`CONV_WORD_WIDTH-1:0] word_t;
  typedef word_t [`CONV_ROWS-1:0] pix_data_t;
  typedef word_t [`CONV_COLS-1:0] wcol_t;

  // Kernel geometry.
  typedef logic [$clog2(`CONV_KW_MAX+1)-1:0]   kw_t;
  typedef logic [$clog2(`CONV_KW_MAX)-1:0]     col_idx_t;
  typedef logic [$clog2(`CONV_REPS_MAX+1)-1:0] rep_t;

  // Low bits of a pixel header beat.
  typedef struct packed {
    logic is_not_max;
    logic is_max;
    logic is_lrelu;
  } pix_mode_t;

  // Low bits of a weight configuration beat.
  typedef struct packed {
    kw_t  kw;
    rep_t reps;
  } w_cfg_t;

  typedef struct packed {
    kw_t  kw2;            // Half kernel width.
    logic is_w_first;
    logic is_cin_last;
    logic is_col_valid;
  } w_tag_t;

  typedef struct packed {
    pix_mode_t mode;
    w_tag_t    tag;
  } conv_user_t;

  typedef enum logic [1:0] {W_IDLE, W_FILL, W_ROTATE} w_state_e;

endpackage

`default_nettype wire

/* logic/conv_input_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_input_pipe (
  input  wire                         aclk,
  input  wire                         rst_n,
  input  wire                         s_pixels_valid,
  output logic                        s_pixels_ready,
  input  wire                         s_pixels_last,
  input  wire conv_in_pkg::pix_data_t s_pixels_data,
  input  wire                         s_weights_valid,
  output logic                        s_weights_ready,
  input  wire                         s_weights_last,
  input  wire conv_in_pkg::wcol_t     s_weights_data,
  input  wire                         m_ready,
  output logic                        m_valid,
  output logic                        m_last,
  output conv_in_pkg::conv_user_t     m_user,
  output conv_in_pkg::pix_data_t      m_pixels_data,
  output conv_in_pkg::wcol_t          m_weights_data
);

  logic                   pix_valid;
  logic                   pix_ready;
  conv_in_pkg::pix_data_t pix_data;
  conv_in_pkg::pix_mode_t pix_mode;
  logic                   w_valid;
  logic                   w_ready;
  logic                   w_last;
  conv_in_pkg::wcol_t     w_data;
  conv_in_pkg::w_tag_t    w_tag;

  pixel_pipe pixel_pipe_i (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (s_pixels_valid),
    .s_last  (s_pixels_last),
    .s_data  (s_pixels_data),
    .m_ready (pix_ready),
    .s_ready (s_pixels_ready),
    .m_valid (pix_valid),
    .m_data  (pix_data),
    .m_mode  (pix_mode)
  );

  weight_rotator weight_rotator_i (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_valid (s_weights_valid),
    .s_last  (s_weights_last),
    .s_data  (s_weights_data),
    .m_ready (w_ready),
    .s_ready (s_weights_ready),
    .m_valid (w_valid),
    .m_last  (w_last),
    .m_data  (w_data),
    .m_tag   (w_tag)
  );

  // ************************************************************
  // Stream join
  // ************************************************************

  assign m_valid   = pix_valid && w_valid;
  assign pix_ready = m_ready && w_valid;
  assign w_ready   = m_ready && pix_valid;

  assign m_last         = w_last && m_valid;
  assign m_pixels_data  = pix_data;
  assign m_weights_data = w_data;

  // Beat flags only count on a valid output.
  assign m_user = '{
    mode: pix_mode,
    tag:  '{
      kw2:          w_tag.kw2,
      is_w_first:   w_tag.is_w_first && m_valid,
      is_cin_last:  w_tag.is_cin_last && m_valid,
      is_col_valid: w_tag.is_col_valid && m_valid
    }
  };

endmodule

`default_nettype wire

/* logic/kernel_col_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module kernel_col_counter (
  input  wire                   aclk,
  input  wire                   rst_n,
  input  wire                   clear,
  input  wire                   step,
  input  wire conv_in_pkg::kw_t  kw,
  input  wire conv_in_pkg::rep_t reps,
  output conv_in_pkg::col_idx_t col,
  output conv_in_pkg::rep_t     round,
  output logic                  col_last,
  output logic                  round_last
);

  assign col_last   = (col == conv_in_pkg::col_idx_t'(kw - 1'b1));
  assign round_last = (round == conv_in_pkg::rep_t'(reps - 1'b1));

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      col   <= '0;
      round <= '0;
    end else if (clear) begin
      col   <= '0;
      round <= '0;
    end else if (step) begin
      if (col_last) begin
        col   <= '0;      // Wrap closes one round.
        round <= round_last ? '0 : round + 1'b1;
      end else begin
        col <= col + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/pixel_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_pipe (
  input  wire                         aclk,
  input  wire                         rst_n,
  input  wire                         s_valid,
  input  wire                         s_last,
  input  wire conv_in_pkg::pix_data_t s_data,
  input  wire                         m_ready,
  output logic                        s_ready,
  output logic                        m_valid,
  output conv_in_pkg::pix_data_t      m_data,
  output conv_in_pkg::pix_mode_t      m_mode
);

  logic                   is_hdr;   // Next beat opens a packet.
  logic                   s_take;
  conv_in_pkg::pix_mode_t mode_q;

  assign s_ready = !m_valid || m_ready;
  assign s_take  = s_valid && s_ready;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      is_hdr <= 1'b1;
      mode_q <= '0;
    end else if (s_take) begin
      is_hdr <= s_last;
      if (is_hdr) begin
        mode_q <= conv_in_pkg::pix_mode_t'(s_data[0][$bits(conv_in_pkg::pix_mode_t)-1:0]);
      end
    end
  end

  // Headers are absorbed.
  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (s_ready) begin
      m_valid <= s_valid && !is_hdr;
    end
  end

  always_ff @(posedge aclk) begin
    if (s_take && !is_hdr) begin
      m_data <= s_data;
      m_mode <= mode_q;
    end
  end

endmodule

`default_nettype wire

/* logic/weight_rotator.sv */
`timescale 1ns/1ps
`default_nettype none
`include "conv_in_cfg.svh"

module weight_rotator (
  input  wire                     aclk,
  input  wire                     rst_n,
  input  wire                     s_valid,
  input  wire                     s_last,
  input  wire conv_in_pkg::wcol_t s_data,
  input  wire                     m_ready,
  output logic                    s_ready,
  output logic                    m_valid,
  output logic                    m_last,
  output conv_in_pkg::wcol_t      m_data,
  output conv_in_pkg::w_tag_t     m_tag
);

  conv_in_pkg::w_state_e state;
  conv_in_pkg::w_cfg_t   cfg_q;
  conv_in_pkg::wcol_t    buf_q [`CONV_KW_MAX];
  conv_in_pkg::col_idx_t col;
  logic                  cnt_clear;
  logic                  cnt_step;
  logic                  col_last;
  logic                  round_last;
  logic                  s_take;
  logic                  rot_load;

  assign s_ready = (state != conv_in_pkg::W_ROTATE);
  assign s_take  = s_valid && s_ready;

  // Next column enters the read register unless the last one is still held.
  assign rot_load = (state == conv_in_pkg::W_ROTATE) && (!m_valid || (m_ready && !m_last));

  weight_seq_fsm fsm_i (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .cfg_take  (s_take),
    .fill_last (s_take && s_last),
    .beat_done (s_take || rot_load),
    .rot_done  (m_valid && m_ready && m_last),
    .state     (state),
    .cnt_clear (cnt_clear),
    .cnt_step  (cnt_step)
  );

  kernel_col_counter counter_i (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .clear      (cnt_clear),
    .step       (cnt_step),
    .kw         (cfg_q.kw),
    .reps       (cfg_q.reps),
    .col        (col),
    .round      (),
    .col_last   (col_last),
    .round_last (round_last)
  );

  // ************************************************************
  // Configuration and column store
  // ************************************************************

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_q <= '0;
    end else if (s_take && state == conv_in_pkg::W_IDLE) begin
      cfg_q <= conv_in_pkg::w_cfg_t'(s_data[0][$bits(conv_in_pkg::w_cfg_t)-1:0]);
    end
  end

  always_ff @(posedge aclk) begin
    if (s_take && state == conv_in_pkg::W_FILL) begin
      buf_q[col] <= s_data;
    end
  end

  // ************************************************************
  // Read register
  // ************************************************************

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      m_valid <= 1'b0;
    end else if (rot_load) begin
      m_valid <= 1'b1;
    end else if (m_ready) begin
      m_valid <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (rot_load) begin
      m_data             <= buf_q[col];
      m_last             <= col_last && round_last;   // End of the final round.
      m_tag.kw2          <= cfg_q.kw >> 1;
      m_tag.is_w_first   <= (col == '0);
      m_tag.is_cin_last  <= round_last;
      m_tag.is_col_valid <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* logic/weight_seq_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_seq_fsm (
  input  wire                   aclk,
  input  wire                   rst_n,
  input  wire                   cfg_take,
  input  wire                   fill_last,
  input  wire                   beat_done,
  input  wire                   rot_done,
  output conv_in_pkg::w_state_e state,
  output logic                  cnt_clear,
  output logic                  cnt_step
);

  conv_in_pkg::w_state_e state_nxt;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= conv_in_pkg::W_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Counter restarts on entry to fill and to replay.
  always_comb begin
    state_nxt = state;
    cnt_clear = 1'b0;
    case (state)
      conv_in_pkg::W_IDLE: begin
        if (cfg_take) begin
          state_nxt = conv_in_pkg::W_FILL;
          cnt_clear = 1'b1;
        end
      end
      conv_in_pkg::W_FILL: begin
        if (fill_last) begin
          state_nxt = conv_in_pkg::W_ROTATE;
          cnt_clear = 1'b1;
        end
      end
      conv_in_pkg::W_ROTATE: begin
        if (rot_done) begin
          state_nxt = conv_in_pkg::W_IDLE;
        end
      end
      default: state_nxt = conv_in_pkg::W_IDLE;
    endcase
  end

  // Column writes in fill, column loads in replay.
  assign cnt_step = beat_done && (state != conv_in_pkg::W_IDLE);

endmodule

`default_nettype wire
